// File: axi_burst_reader.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_reader
   import dma_axi_pkg::*, dma_ctrl_pkg::*;
(
   input  wire        clk_i,
   input  wire        reset_i,

   input  wire        burst_start_i,
   input  axi_addr_t  burst_addr_i,
   input  burst_len_t burst_len_i,
   output logic       busy_o,

   // AXI read address channel
   output logic       arvalid_o,
   input  wire        arready_i,
   output axi_ar_t    ar_o,

   // AXI read data channel
   input  wire        rvalid_i,
   output logic       rready_o,
   input  axi_r_t     r_i,

   // FIFO write side
   input  wire        fifo_full_i,
   output logic       fifo_wen_o,
   output axi_data_t  fifo_wdata_o
);

   reader_state_t state;
   axi_addr_t     addr_q;
   burst_len_t    len_q;
   burst_len_t    len_m1;
   logic          beat;

   assign len_m1 = len_q - burst_len_t'(1);

   always_comb begin
      ar_o.addr = addr_q;
      ar_o.len  = len_m1[AXI_LEN_W-1:0];
      ar_o.id   = '0;
   end

   // Strobe counts as busy so the engine sees no idle gap
   assign busy_o = (state != RD_IDLE) || burst_start_i;

   assign arvalid_o = (state == RD_ADDR);
   assign rready_o  = (state == RD_DATA) && !fifo_full_i;

   assign beat         = rvalid_i && rready_o;
   assign fifo_wen_o   = beat;
   assign fifo_wdata_o = r_i.data;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state <= RD_IDLE;
      end else begin
         case (state)
            RD_IDLE: begin
               if (burst_start_i) begin
                  state <= RD_ADDR;
               end
            end
            RD_ADDR: begin
               if (arready_i) begin
                  state <= RD_DATA;
               end
            end
            RD_DATA: begin
               if (beat && r_i.last) begin
                  state <= RD_IDLE;
               end
            end
            default: begin
               state <= RD_IDLE;
            end
         endcase
      end
   end

   // Request captured at the strobe, held through the burst
   always_ff @(posedge clk_i) begin
      if ((state == RD_IDLE) && burst_start_i) begin
         addr_q <= burst_addr_i;
         len_q  <= burst_len_i;
      end
   end

endmodule

`default_nettype wire

// File: dma_axi_pkg.sv
`default_nettype none

package dma_axi_pkg;

   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;
   localparam int AXI_LEN_W  = 4;
   localparam int AXI_ID_W   = 1;

   typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [AXI_DATA_W-1:0] axi_data_t;

   // Beats minus one
   typedef logic [AXI_LEN_W-1:0] axi_len_t;

   typedef logic [AXI_ID_W-1:0] axi_id_t;

   typedef logic [1:0] axi_resp_t;

   // Read address payload
   typedef struct packed {
      axi_addr_t addr;
      axi_len_t  len;
      axi_id_t   id;
   } axi_ar_t;

   // Read data payload
   typedef struct packed {
      axi_data_t data;
      axi_resp_t resp;
      logic      last;
      axi_id_t   id;
   } axi_r_t;

endpackage

`default_nettype wire

// File: dma_ctrl_pkg.sv
`default_nettype none

package dma_ctrl_pkg;

   import dma_axi_pkg::*;

   localparam int DMA_RLEN_W = 16;
   localparam int FIFO_DEPTH = 1 << AXI_LEN_W;

   // 1 to 16 words
   typedef logic [AXI_LEN_W:0] burst_len_t;

   // 0 to 16 words
   typedef logic [AXI_LEN_W:0] fifo_level_t;

   typedef logic [DMA_RLEN_W-1:0] rlen_t;

   typedef enum logic [0:0] {
      WAIT_START,
      WAIT_SPACE
   } engine_state_t;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ADDR,
      RD_DATA
   } reader_state_t;

endpackage

`default_nettype wire

// File: dma_read_engine.f
dma_axi_pkg.sv
dma_ctrl_pkg.sv
sync_fifo.sv
axi_burst_reader.sv
fifo_to_stream.sv
dma_read_engine.sv
dma_read_props.sv
tb_dma_read.sv

// File: dma_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module dma_read_engine
   import dma_axi_pkg::*, dma_ctrl_pkg::*;
(
   input  wire        clk_i,
   input  wire        reset_i,

   // Control
   input  wire        start_i,
   input  axi_addr_t  addr_i,
   input  rlen_t      length_i,
   input  burst_len_t max_len_i,
   output logic       busy_o,
   output rlen_t      remaining_o,

   // AXI read address channel
   output logic       arvalid_o,
   input  wire        arready_i,
   output axi_ar_t    ar_o,

   // AXI read data channel
   input  wire        rvalid_i,
   output logic       rready_o,
   input  axi_r_t     r_i,

   // Output stream
   output logic       tvalid_o,
   input  wire        tready_i,
   output axi_data_t  tdata_o
);

   engine_state_t state;
   engine_state_t state_nxt;
   rlen_t         remaining_q;
   rlen_t         remaining_nxt;
   axi_addr_t     addr_q;
   axi_addr_t     addr_nxt;
   burst_len_t    next_len;
   logic          burst_go;

   // Request to the reader, one cycle after the decision
   logic          burst_start;
   axi_addr_t     burst_addr;
   burst_len_t    burst_len;
   logic          reader_busy;

   logic          fifo_wen;
   axi_data_t     fifo_wdata;
   logic          fifo_full;
   logic          fifo_ren;
   axi_data_t     fifo_rdata;
   logic          fifo_empty;
   fifo_level_t   fifo_level;
   fifo_level_t   space_in_fifo;

   assign space_in_fifo = fifo_level_t'(FIFO_DEPTH) - fifo_level;

   assign busy_o      = (state != WAIT_START);
   assign remaining_o = remaining_q;

   always_comb begin
      state_nxt     = state;
      remaining_nxt = remaining_q;
      addr_nxt      = addr_q;
      next_len      = '0;
      burst_go      = 1'b0;

      case (state)
         WAIT_START: begin
            if (start_i) begin
               remaining_nxt = length_i;
               addr_nxt      = addr_i;
               state_nxt     = WAIT_SPACE;
            end
         end
         WAIT_SPACE: begin
            if (!reader_busy) begin
               if (remaining_q == '0) begin
                  state_nxt = WAIT_START;
               end else begin
                  // Tail burst if it fits, else a full max_len burst
                  if ((remaining_q <= rlen_t'(space_in_fifo)) &&
                      (remaining_q <= rlen_t'(max_len_i))) begin
                     next_len = burst_len_t'(remaining_q);
                  end else if (space_in_fifo >= max_len_i) begin
                     next_len = max_len_i;
                  end

                  if (next_len != '0) begin
                     burst_go      = 1'b1;
                     remaining_nxt = remaining_q - rlen_t'(next_len);
                     addr_nxt      = addr_q + (axi_addr_t'(next_len) << 2);
                  end
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state       <= WAIT_START;
         remaining_q <= '0;
         burst_start <= 1'b0;
      end else begin
         state       <= state_nxt;
         remaining_q <= remaining_nxt;
         burst_start <= burst_go;
      end
   end

   always_ff @(posedge clk_i) begin
      addr_q <= addr_nxt;
      if (burst_go) begin
         burst_addr <= addr_q;
         burst_len  <= next_len;
      end
   end

   axi_burst_reader reader_inst (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .burst_start_i(burst_start),
      .burst_addr_i (burst_addr),
      .burst_len_i  (burst_len),
      .busy_o       (reader_busy),
      .arvalid_o    (arvalid_o),
      .arready_i    (arready_i),
      .ar_o         (ar_o),
      .rvalid_i     (rvalid_i),
      .rready_o     (rready_o),
      .r_i          (r_i),
      .fifo_full_i  (fifo_full),
      .fifo_wen_o   (fifo_wen),
      .fifo_wdata_o (fifo_wdata)
   );

   sync_fifo buffer_inst (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .w_en_i  (fifo_wen),
      .w_data_i(fifo_wdata),
      .full_o  (fifo_full),
      .r_en_i  (fifo_ren),
      .r_data_o(fifo_rdata),
      .empty_o (fifo_empty),
      .level_o (fifo_level)
   );

   fifo_to_stream stream_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .fifo_empty_i(fifo_empty),
      .fifo_read_o (fifo_ren),
      .fifo_rdata_i(fifo_rdata),
      .tvalid_o    (tvalid_o),
      .tdata_o     (tdata_o),
      .tready_i    (tready_i)
   );

endmodule

`default_nettype wire

// File: dma_read_props.sv
`timescale 1ns/1ps
`default_nettype none

module dma_read_props
   import dma_axi_pkg::*, dma_ctrl_pkg::*;
(
   input wire              clk_i,
   input wire              reset_i,
   input wire              arvalid_i,
   input wire              arready_i,
   input wire axi_ar_t     ar_i,
   input wire              tvalid_i,
   input wire              tready_i,
   input wire axi_data_t   tdata_i,
   input wire burst_len_t  max_len_i,
   input wire              rvalid_i,
   input wire              fifo_full_i
);

   // Failures so far, polled from the testbench top
   int fail_count = 0;

   // AR request held with a fixed payload until arready
   ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
      else begin
         fail_count = fail_count + 1;
         $error("AR request changed before it was accepted");
      end

   stream_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      tvalid_i && !tready_i |=> tvalid_i && $stable(tdata_i))
      else begin
         fail_count = fail_count + 1;
         $error("Stream word changed before it was accepted");
      end

   // AXI len field encodes beats minus one
   ar_len_limit: assert property (@(posedge clk_i) disable iff (reset_i)
      arvalid_i |-> (burst_len_t'(ar_i.len) + burst_len_t'(1)) <= max_len_i)
      else begin
         fail_count = fail_count + 1;
         $error("AR burst longer than the maximum burst length");
      end

   // Sizing leaves room in the FIFO for every beat of a burst
   no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
      rvalid_i |-> !fifo_full_i)
      else begin
         fail_count = fail_count + 1;
         $error("Read beat waiting on a full FIFO");
      end

endmodule

bind dma_read_engine dma_read_props props_inst (
   .clk_i      (clk_i),
   .reset_i    (reset_i),
   .arvalid_i  (arvalid_o),
   .arready_i  (arready_i),
   .ar_i       (ar_o),
   .tvalid_i   (tvalid_o),
   .tready_i   (tready_i),
   .tdata_i    (tdata_o),
   .max_len_i  (max_len_i),
   .rvalid_i   (rvalid_i),
   .fifo_full_i(fifo_full)
);

`default_nettype wire

// File: fifo_to_stream.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_to_stream
   import dma_axi_pkg::*;
(
   input  wire       clk_i,
   input  wire       reset_i,

   input  wire       fifo_empty_i,
   output logic      fifo_read_o,
   input  axi_data_t fifo_rdata_i,

   output logic      tvalid_o,
   output axi_data_t tdata_o,
   input  wire       tready_i
);

   // Word sitting on the FIFO read port, not yet taken
   logic      rd_pend;
   logic      out_full;
   logic      move;
   axi_data_t out_q;

   // Output register refills when empty or draining this cycle
   assign move = rd_pend && (!out_full || tready_i);

   // FIFO read port holds its word until the next read
   assign fifo_read_o = !fifo_empty_i && (!rd_pend || move);

   assign tvalid_o = out_full;
   assign tdata_o  = out_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_pend  <= 1'b0;
         out_full <= 1'b0;
      end else begin
         if (fifo_read_o) begin
            rd_pend <= 1'b1;
         end else if (move) begin
            rd_pend <= 1'b0;
         end
         if (move) begin
            out_full <= 1'b1;
         end else if (tready_i) begin
            out_full <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (move) begin
         out_q <= fifo_rdata_i;
      end
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the DMA read engine testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dma_read \
   -f dma_read_engine.f \
   -o sim_dma_read \
   && ./obj_dir/sim_dma_read | tee /dev/stderr | grep -F "STATUS: PASS" > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// File: sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
   import dma_axi_pkg::*, dma_ctrl_pkg::*;
(
   input  wire         clk_i,
   input  wire         reset_i,
   input  wire         w_en_i,
   input  axi_data_t   w_data_i,
   output logic        full_o,
   input  wire         r_en_i,
   output axi_data_t   r_data_o,
   output logic        empty_o,
   output fifo_level_t level_o
);

   axi_data_t            mem [FIFO_DEPTH];
   logic [AXI_LEN_W-1:0] w_ptr;
   logic [AXI_LEN_W-1:0] r_ptr;
   fifo_level_t          level;
   logic                 do_write;
   logic                 do_read;

   assign full_o  = (level == fifo_level_t'(FIFO_DEPTH));
   assign empty_o = (level == '0);
   assign level_o = level;

   // Overflow and underflow attempts are dropped
   assign do_write = w_en_i && !full_o;
   assign do_read  = r_en_i && !empty_o;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         w_ptr <= '0;
         r_ptr <= '0;
         level <= '0;
      end else begin
         if (do_write) begin
            w_ptr <= w_ptr + 1'b1;
         end
         if (do_read) begin
            r_ptr <= r_ptr + 1'b1;
         end
         if (do_write && !do_read) begin
            level <= level + 1'b1;
         end else if (do_read && !do_write) begin
            level <= level - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_write) begin
         mem[w_ptr] <= w_data_i;
      end
   end

   // Registered read port, data follows r_en_i by one cycle
   always_ff @(posedge clk_i) begin
      if (do_read) begin
         r_data_o <= mem[r_ptr];
      end
   end

endmodule

`default_nettype wire

// File: tb_dma_read.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_read
   import dma_axi_pkg::*, dma_ctrl_pkg::*;
();

   localparam int          SEED       = 85417;
   localparam int          CLK_PERIOD = 20;
   localparam int          MEM_WORDS  = 1024;
   localparam logic [31:0] MIX        = 32'h5A3C_96E1;

   // Transfer lengths in words, in run order
   localparam int LEN_SHORT   = 5;
   localparam int LEN_LONG    = 70;
   localparam int LEN_RAND    = 123;
   localparam int LEN_B2B_0   = 9;
   localparam int LEN_B2B_1   = 33;
   localparam int LEN_B2B_2   = 17;
   localparam int TOTAL_WORDS = LEN_SHORT + LEN_LONG + LEN_RAND + LEN_B2B_0 + LEN_B2B_1 +
                                LEN_B2B_2;
   localparam int TRANSFERS   = 7;

   // Random gaps on every channel at worst cost a handful of cycles per word
   localparam int CYCLES_PER_WORD = 16;
   localparam int WATCHDOG_NS     = (TOTAL_WORDS * CYCLES_PER_WORD + TRANSFERS * 100) *
                                    CLK_PERIOD;

   logic       clk_i;
   logic       reset_i;
   logic       start_i;
   axi_addr_t  addr_i;
   rlen_t      length_i;
   burst_len_t max_len_i;
   logic       busy_o;
   rlen_t      remaining_o;
   logic       arvalid_o;
   logic       arready_i;
   axi_ar_t    ar_o;
   logic       rvalid_i;
   logic       rready_o;
   axi_r_t     r_i;
   logic       tvalid_o;
   logic       tready_i;
   axi_data_t  tdata_o;

   axi_data_t mem [MEM_WORDS];
   axi_ar_t   ar_q[$];
   axi_ar_t   exp_ar[$];
   axi_data_t exp_data[$];
   int        beat_idx;
   logic      r_taken;
   logic      random_axi;
   logic      random_tready;
   int        words_seen;

   dma_read_engine i_dut (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .start_i    (start_i),
      .addr_i     (addr_i),
      .length_i   (length_i),
      .max_len_i  (max_len_i),
      .busy_o     (busy_o),
      .remaining_o(remaining_o),
      .arvalid_o  (arvalid_o),
      .arready_i  (arready_i),
      .ar_o       (ar_o),
      .rvalid_i   (rvalid_i),
      .rready_o   (rready_o),
      .r_i        (r_i),
      .tvalid_o   (tvalid_o),
      .tready_i   (tready_i),
      .tdata_o    (tdata_o)
   );

   initial clk_i = 1'b0;
   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   function automatic axi_data_t expected_word(input axi_addr_t addr);
      logic [31:0] idx;
      idx = addr >> 2;
      return {idx[15:0], ~idx[15:0]} ^ MIX;
   endfunction

   // Every burst is min(remaining, max_len), the FIFO only delays it
   function automatic void expected_bursts(input axi_addr_t addr, input int len,
                                           input int max_len);
      int        left;
      int        n;
      axi_addr_t a;
      axi_ar_t   req;
      left = len;
      a    = addr;
      while (left > 0) begin
         n        = (left < max_len) ? left : max_len;
         req.addr = a;
         req.len  = axi_len_t'(n - 1);
         req.id   = '0;
         exp_ar.push_back(req);
         a    = a + axi_addr_t'(4 * n);
         left = left - n;
      end
   endfunction

   task automatic check_equal(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // AXI slave, R before AR so data never precedes its own AR handshake
   always @(negedge clk_i) begin
      int widx;
      if (!reset_i) begin
         if (r_taken) begin
            rvalid_i = 1'b0;
         end
         if (!rvalid_i && ar_q.size() != 0 && (!random_axi || ($urandom % 4) != 0)) begin
            widx       = int'(ar_q[0].addr >> 2) + beat_idx;
            r_i.data   = mem[widx % MEM_WORDS];
            r_i.resp   = 2'b00;
            r_i.id     = ar_q[0].id;
            r_i.last   = (beat_idx == int'(ar_q[0].len));
            rvalid_i   = 1'b1;
         end
         r_taken = rvalid_i && rready_o;
         if (r_taken) begin
            if (r_i.last) begin
               beat_idx = 0;
               ar_q.delete(0);
            end else begin
               beat_idx++;
            end
         end

         arready_i = !random_axi || ($urandom % 3) == 0;
         if (arvalid_o && arready_i) begin
            check_equal("AR expected", exp_ar.size() != 0, 1);
            check_equal("AR address", ar_o.addr, exp_ar[0].addr);
            check_equal("AR length", ar_o.len, exp_ar[0].len);
            check_equal("AR id", ar_o.id, exp_ar[0].id);
            ar_q.push_back(ar_o);
            exp_ar.delete(0);
         end
      end
   end

   // Stream sink and in-order compare
   always @(negedge clk_i) begin
      if (!reset_i) begin
         tready_i = !random_tready || ($urandom % 2) == 0;
         if (tvalid_o && tready_i) begin
            check_equal("stream word expected", exp_data.size() != 0, 1);
            check_equal("stream data", tdata_o, exp_data[0]);
            exp_data.delete(0);
            words_seen++;
         end
      end
   end

   // Bound assertions count their failures
   always @(negedge clk_i) begin
      check_equal("assertion failures", i_dut.props_inst.fail_count, 0);
   end

   task automatic run_transfer(input axi_addr_t addr, input int len, input int max_len);
      int i;
      expected_bursts(addr, len, max_len);
      for (i = 0; i < len; i++) begin
         exp_data.push_back(expected_word(addr + axi_addr_t'(4 * i)));
      end
      addr_i    = addr;
      length_i  = rlen_t'(len);
      max_len_i = burst_len_t'(max_len);
      start_i   = 1'b1;
      @(negedge clk_i);
      start_i = 1'b0;
      check_equal("busy after start", busy_o, 1);
      check_equal("remaining after start", remaining_o, len);
      while (busy_o) begin
         @(negedge clk_i);
      end
      check_equal("remaining at end", remaining_o, 0);
      // Stream may still be draining after busy falls
      while (exp_data.size() != 0) begin
         @(negedge clk_i);
      end
      check_equal("bursts not issued", exp_ar.size(), 0);
   endtask

   initial begin
      int i;
      void'($urandom(SEED));
      reset_i       = 1'b1;
      start_i       = 1'b0;
      addr_i        = '0;
      length_i      = '0;
      max_len_i     = burst_len_t'(16);
      arready_i     = 1'b0;
      rvalid_i      = 1'b0;
      r_i           = '0;
      tready_i      = 1'b0;
      random_axi    = 1'b0;
      random_tready = 1'b0;
      r_taken       = 1'b0;
      beat_idx      = 0;
      words_seen    = 0;
      for (i = 0; i < MEM_WORDS; i++) begin
         mem[i] = {i[15:0], ~i[15:0]} ^ MIX;
      end

      repeat (2) @(negedge clk_i);
      reset_i = 1'b0;

      check_equal("busy after reset", busy_o, 0);
      check_equal("arvalid after reset", arvalid_o, 0);
      check_equal("tvalid after reset", tvalid_o, 0);
      check_equal("remaining after reset", remaining_o, 0);

      run_transfer(32'h0000_0040, 0, 16);
      run_transfer(32'h0000_0100, LEN_SHORT, 16);
      run_transfer(32'h0000_0400, LEN_LONG, 16);

      random_axi    = 1'b1;
      random_tready = 1'b1;
      run_transfer(32'h0000_0800, LEN_RAND, 12);

      // Back to back with changing max_len
      run_transfer(32'h0000_0C00, LEN_B2B_0, 4);
      run_transfer(32'h0000_0D00, LEN_B2B_1, 16);
      run_transfer(32'h0000_0E00, LEN_B2B_2, 1);

      check_equal("words delivered", words_seen, TOTAL_WORDS);
      check_equal("assertion failures", i_dut.props_inst.fail_count, 0);
      $display("STATUS: PASS");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the transfers did not complete within %0d ns", WATCHDOG_NS);
      $display("STATUS: FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire
